/* src/aes_settings.svh */
//----------------------------------------
// aes-128 encipher settings
// round count, block geometry and the
// byte and word widths of the state
//----------------------------------------
`ifndef AES_SETTINGS_SVH
`define AES_SETTINGS_SVH

// rounds after the initial key add
`define AES_ROUNDS 10

// 32-bit columns per block
`define AES_WORDS 4

// byte and column widths
`define AES_BYTE_BITS 8
`define AES_WORD_BITS 32

`endif

/* src/aes_pkg.sv */
//----------------------------------------
// aes-128 encipher types
// vector typedefs and the round type and
// controller state encodings
//----------------------------------------
`include "aes_settings.svh"

package aes_pkg;

  // one state byte
  typedef logic [`AES_BYTE_BITS-1:0] byte_t;

  // one state column, also the s-box word
  typedef logic [`AES_WORD_BITS-1:0] word_t;

  // data block, state or round key
  typedef logic [`AES_WORDS*`AES_WORD_BITS-1:0] block_t;

  // round number 0..10
  typedef logic [3:0] round_t;

  // index of the word in subbytes
  typedef logic [1:0] sword_t;

  // which round result the round logic gives
  typedef enum logic [1:0] {init_round, main_round, final_round} round_type_e;

  // encipher controller states
  typedef enum logic [2:0] {ctrl_idle, ctrl_init, ctrl_sbox, ctrl_round, ctrl_done} enc_state_e;

endpackage

/* src/aes_sbox.sv */
//----------------------------------------
// aes forward s-box
// substitutes all four bytes of one word
//----------------------------------------
`timescale 1ns/1ps
`include "aes_settings.svh"

module aes_sbox (
  input  aes_pkg::word_t sboxw,
  output aes_pkg::word_t new_sboxw
);
  import aes_pkg::*;

  localparam int word_bytes = `AES_WORD_BITS / `AES_BYTE_BITS;

  // forward substitution table, fips-197
  localparam byte_t sbox_table [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // one lookup per byte lane
  always_comb
  begin
    for (int i = 0; i < word_bytes; i++)
    begin
      new_sboxw[i*`AES_BYTE_BITS +: `AES_BYTE_BITS] =
        sbox_table[sboxw[i*`AES_BYTE_BITS +: `AES_BYTE_BITS]];
    end
  end

endmodule

/* src/aes_round_logic.sv */
//----------------------------------------
// aes-128 encipher round logic
// combinational init, main and final
// round results from the current state
//----------------------------------------
`timescale 1ns/1ps
`include "aes_settings.svh"

module aes_round_logic (
  input  aes_pkg::block_t      state,
  input  aes_pkg::block_t      block,
  input  aes_pkg::block_t      round_key,
  input  aes_pkg::round_type_e round_type,
  output aes_pkg::block_t      round_result
);
  import aes_pkg::*;

  localparam int word_bytes = `AES_WORD_BITS / `AES_BYTE_BITS;
  localparam int block_msb  = `AES_WORDS * `AES_WORD_BITS - 1;

  // ----------------------------------------
  // gf(2^8) helpers
  // ----------------------------------------
  // multiply by x, reduce by the aes polynomial
  function automatic byte_t gm2(byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic byte_t gm3(byte_t b);
    return gm2(b) ^ b;
  endfunction

  // one column through the mixcolumns matrix
  function automatic word_t mix_column(word_t w);
    byte_t b0;
    byte_t b1;
    byte_t b2;
    byte_t b3;
    b0 = w[31:24];
    b1 = w[23:16];
    b2 = w[15:8];
    b3 = w[7:0];
    return {gm2(b0) ^ gm3(b1) ^ b2 ^ b3,
            b0 ^ gm2(b1) ^ gm3(b2) ^ b3,
            b0 ^ b1 ^ gm2(b2) ^ gm3(b3),
            gm3(b0) ^ b1 ^ b2 ^ gm2(b3)};
  endfunction

  function automatic block_t mix_columns(block_t b);
    block_t res;
    res = '0;
    for (int c = 0; c < `AES_WORDS; c++)
    begin
      res[block_msb - c*`AES_WORD_BITS -: `AES_WORD_BITS] =
        mix_column(b[block_msb - c*`AES_WORD_BITS -: `AES_WORD_BITS]);
    end
    return res;
  endfunction

  // row r rotates left by r columns
  // byte r of column c sits at 4c+r from the msb
  function automatic block_t shift_rows(block_t b);
    block_t res;
    int     src;
    res = '0;
    for (int c = 0; c < `AES_WORDS; c++)
    begin
      for (int r = 0; r < word_bytes; r++)
      begin
        src = (c + r) % `AES_WORDS;
        res[block_msb - (word_bytes*c + r)*`AES_BYTE_BITS -: `AES_BYTE_BITS] =
          b[block_msb - (word_bytes*src + r)*`AES_BYTE_BITS -: `AES_BYTE_BITS];
      end
    end
    return res;
  endfunction

  // ----------------------------------------
  // round select
  // ----------------------------------------
  // state is already through subbytes in main and final rounds
  always_comb
  begin
    case (round_type)
      init_round:
        round_result = block ^ round_key;
      main_round:
        round_result = mix_columns(shift_rows(state)) ^ round_key;
      final_round:
        // no mixcolumns, key still added
        round_result = shift_rows(state) ^ round_key;
      default:
        round_result = '0;
    endcase
  end

endmodule

/* src/aes_block_state.sv */
//----------------------------------------
// aes-128 block state register
// four column words, s-box word select
// and write-back, round result load
//----------------------------------------
`timescale 1ns/1ps
`include "aes_settings.svh"

module aes_block_state (
  input  logic            clk,
  input  logic            reset_n,
  input  aes_pkg::sword_t sword_idx,
  input  logic            sbox_we,
  input  logic            update_we,
  input  aes_pkg::word_t  new_sboxw,
  input  aes_pkg::block_t round_result,
  output aes_pkg::word_t  sboxw,
  output aes_pkg::block_t state
);
  import aes_pkg::*;

  word_t                 words_reg [`AES_WORDS];
  word_t                 words_new [`AES_WORDS];
  logic [`AES_WORDS-1:0] words_we;

  // ----------------------------------------
  // per-word write enables and next values
  // ----------------------------------------
  // round update writes all words, subbytes only the selected one
  always_comb
  begin
    for (int i = 0; i < `AES_WORDS; i++)
    begin
      words_we[i] = update_we || (sbox_we && (sword_idx == sword_t'(i)));
      if (update_we)
      begin
        words_new[i] = round_result[(`AES_WORDS-1-i)*`AES_WORD_BITS +: `AES_WORD_BITS];
      end
      else
      begin
        words_new[i] = new_sboxw;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      for (int i = 0; i < `AES_WORDS; i++)
      begin
        words_reg[i] <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < `AES_WORDS; i++)
      begin
        if (words_we[i])
        begin
          words_reg[i] <= words_new[i];
        end
      end
    end
  end

  // word 0 is the top column of the block
  always_comb
  begin
    for (int i = 0; i < `AES_WORDS; i++)
    begin
      state[(`AES_WORDS-1-i)*`AES_WORD_BITS +: `AES_WORD_BITS] = words_reg[i];
    end
  end

  // column going out to the s-box
  assign sboxw = words_reg[sword_idx];

  // controller must never ask for both writes at once
  a_one_write: assert property (@(posedge clk) disable iff (!reset_n)
    !(sbox_we && update_we));

endmodule

/* src/aes_encipher_ctrl.sv */
//----------------------------------------
// aes-128 encipher controller
// fsm, round and word counters, ready
// level, 51 cycles from next to ready
//----------------------------------------
`timescale 1ns/1ps
`include "aes_settings.svh"

module aes_encipher_ctrl (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 next,
  output aes_pkg::round_t      round,
  output aes_pkg::round_type_e round_type,
  output aes_pkg::sword_t      sword_idx,
  output logic                 sbox_we,
  output logic                 update_we,
  output logic                 ready
);
  import aes_pkg::*;

  // ----------------------------------------
  // registers and update strobes
  // ----------------------------------------
  enc_state_e state_reg;
  enc_state_e state_new;
  logic       state_we;

  round_t     round_ctr_reg;
  round_t     round_ctr_new;
  logic       round_ctr_we;
  logic       round_ctr_rst;
  logic       round_ctr_inc;

  sword_t     sword_ctr_reg;
  sword_t     sword_ctr_new;
  logic       sword_ctr_we;
  logic       sword_ctr_rst;
  logic       sword_ctr_inc;

  logic       ready_reg;
  logic       ready_new;
  logic       ready_we;

  assign round     = round_ctr_reg;
  assign sword_idx = sword_ctr_reg;
  assign ready     = ready_reg;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state_reg     <= ctrl_idle;
      round_ctr_reg <= '0;
      sword_ctr_reg <= '0;
      ready_reg     <= 1'b1;
    end
    else
    begin
      if (state_we)
      begin
        state_reg <= state_new;
      end
      if (round_ctr_we)
      begin
        round_ctr_reg <= round_ctr_new;
      end
      if (sword_ctr_we)
      begin
        sword_ctr_reg <= sword_ctr_new;
      end
      if (ready_we)
      begin
        ready_reg <= ready_new;
      end
    end
  end

  // round counter, reset wins over increment
  always_comb
  begin
    round_ctr_new = '0;
    round_ctr_we  = 1'b0;
    if (round_ctr_rst)
    begin
      round_ctr_we = 1'b1;
    end
    else if (round_ctr_inc)
    begin
      round_ctr_new = round_ctr_reg + 4'h1;
      round_ctr_we  = 1'b1;
    end
  end

  // subbytes word counter, wraps back to 0 after the last word
  always_comb
  begin
    sword_ctr_new = '0;
    sword_ctr_we  = 1'b0;
    if (sword_ctr_rst)
    begin
      sword_ctr_we = 1'b1;
    end
    else if (sword_ctr_inc)
    begin
      sword_ctr_new = sword_ctr_reg + 2'h1;
      sword_ctr_we  = 1'b1;
    end
  end

  // init uses the block, last round skips mixcolumns
  always_comb
  begin
    if (state_reg == ctrl_init)
    begin
      round_type = init_round;
    end
    else if (round_ctr_reg == round_t'(`AES_ROUNDS))
    begin
      round_type = final_round;
    end
    else
    begin
      round_type = main_round;
    end
  end

  // ----------------------------------------
  // encipher fsm
  // ----------------------------------------
  always_comb
  begin
    state_new     = ctrl_idle;
    state_we      = 1'b0;
    round_ctr_rst = 1'b0;
    round_ctr_inc = 1'b0;
    sword_ctr_rst = 1'b0;
    sword_ctr_inc = 1'b0;
    ready_new     = 1'b0;
    ready_we      = 1'b0;
    sbox_we       = 1'b0;
    update_we     = 1'b0;

    case (state_reg)
      ctrl_idle:
      begin
        // start only while ready, ready falls on this edge
        if (next && ready_reg)
        begin
          round_ctr_rst = 1'b1;
          sword_ctr_rst = 1'b1;
          ready_we      = 1'b1;
          state_new     = ctrl_init;
          state_we      = 1'b1;
        end
      end

      ctrl_init:
      begin
        // block xor key 0, then round 1
        update_we     = 1'b1;
        round_ctr_inc = 1'b1;
        state_new     = ctrl_sbox;
        state_we      = 1'b1;
      end

      ctrl_sbox:
      begin
        // one word per cycle
        sbox_we       = 1'b1;
        sword_ctr_inc = 1'b1;
        if (sword_ctr_reg == sword_t'(`AES_WORDS - 1))
        begin
          state_new = ctrl_round;
          state_we  = 1'b1;
        end
      end

      ctrl_round:
      begin
        update_we = 1'b1;
        state_we  = 1'b1;
        if (round_ctr_reg == round_t'(`AES_ROUNDS))
        begin
          // result written and ready raised on the same edge
          ready_new = 1'b1;
          ready_we  = 1'b1;
          state_new = ctrl_done;
        end
        else
        begin
          round_ctr_inc = 1'b1;
          state_new     = ctrl_sbox;
        end
      end

      ctrl_done:
      begin
        // ready is already high here, a start is taken too
        round_ctr_rst = 1'b1;
        sword_ctr_rst = 1'b1;
        state_we      = 1'b1;
        if (next)
        begin
          ready_we  = 1'b1;
          state_new = ctrl_init;
        end
      end

      default:
      begin
        state_we = 1'b1;
      end
    endcase
  end

  // ----------------------------------------
  // assertions
  // ----------------------------------------
  a_round_max: assert property (@(posedge clk) disable iff (!reset_n)
    round_ctr_reg <= round_t'(`AES_ROUNDS));

  // word index only moves while substituting
  a_sword_move: assert property (@(posedge clk) disable iff (!reset_n)
    ($past(reset_n) && $changed(sword_ctr_reg)) |-> $past(state_reg == ctrl_sbox));

endmodule

/* src/aes_encipher_core.sv */
//----------------------------------------
// aes-128 encipher core
// iterative core, one block per start,
// round keys from an external source
//----------------------------------------
`timescale 1ns/1ps

module aes_encipher_core (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            next,
  input  aes_pkg::block_t block,
  input  aes_pkg::block_t round_key,
  output aes_pkg::round_t round,
  output aes_pkg::block_t new_block,
  output logic            ready
);
  import aes_pkg::*;

  // controller to datapath
  round_type_e round_type;
  sword_t      sword_idx;
  logic        sbox_we;
  logic        update_we;

  // s-box word path and round result
  word_t       sboxw;
  word_t       new_sboxw;
  block_t      round_result;

  aes_encipher_ctrl u_ctrl (
    .clk        (clk),
    .reset_n    (reset_n),
    .next       (next),
    .round      (round),
    .round_type (round_type),
    .sword_idx  (sword_idx),
    .sbox_we    (sbox_we),
    .update_we  (update_we),
    .ready      (ready)
  );

  // state register drives new_block directly
  aes_block_state u_state (
    .clk          (clk),
    .reset_n      (reset_n),
    .sword_idx    (sword_idx),
    .sbox_we      (sbox_we),
    .update_we    (update_we),
    .new_sboxw    (new_sboxw),
    .round_result (round_result),
    .sboxw        (sboxw),
    .state        (new_block)
  );

  aes_round_logic u_round (
    .state        (new_block),
    .block        (block),
    .round_key    (round_key),
    .round_type   (round_type),
    .round_result (round_result)
  );

  aes_sbox u_sbox (
    .sboxw     (sboxw),
    .new_sboxw (new_sboxw)
  );

endmodule

/* bench/aes_checker.sv */
//----------------------------------------
// aes-128 encipher checker
// own reference model, latency count,
// result compare and per-test report
//----------------------------------------
`timescale 1ns/1ps
`include "aes_settings.svh"

module aes_checker (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            next,
  input  logic            ready,
  input  aes_pkg::round_t round,
  input  aes_pkg::block_t cipher_key,
  input  aes_pkg::block_t block,
  input  aes_pkg::block_t new_block,
  output int              errors,
  output int              tests
);
  import aes_pkg::*;

  // one init cycle, then four s-box cycles and one update per round
  localparam int exp_latency = 1 + `AES_ROUNDS * (`AES_WORDS + 1);

  // fips-197 appendix c.1
  localparam block_t fips_key = 128'h000102030405060708090a0b0c0d0e0f;
  localparam block_t fips_pt  = 128'h00112233445566778899aabbccddeeff;
  localparam block_t fips_ct  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

  bit     busy         = 1'b0;
  bit     in_reset     = 1'b0;
  bit     self_checked = 1'b0;
  bit     op_ok        = 1'b0;
  bit     round_ok     = 1'b0;
  int     low_cycles   = 0;
  int     ops          = 0;
  int     err_cnt      = 0;
  int     test_cnt     = 0;
  block_t expected     = '0;
  block_t last_result  = '0;

  assign errors = err_cnt;
  assign tests  = test_cnt;

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  // gf(2^8) product, shift and add
  function automatic logic [7:0] gf_mul(logic [7:0] a, logic [7:0] b);
    logic [7:0] p;
    p = 8'h00;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
      begin
        p = p ^ a;
      end
      a = {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    end
    return p;
  endfunction

  // inverse as b^254, then the affine map
  function automatic logic [7:0] sub_byte(logic [7:0] b);
    logic [7:0] sq;
    logic [7:0] inv;
    sq  = b;
    inv = 8'h01;
    for (int i = 1; i < 8; i++)
    begin
      sq  = gf_mul(sq, sq);
      inv = gf_mul(inv, sq);
    end
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^
           {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
  endfunction

  // byte i of the state is row i%4 of column i/4
  function automatic block_t encrypt(block_t key, block_t pt);
    logic [31:0] w [44];
    logic [31:0] t;
    logic [7:0]  rcon;
    logic [7:0]  s [16];
    logic [7:0]  sr [16];
    block_t      res;
    rcon = 8'h01;
    for (int i = 0; i < 4; i++)
    begin
      w[i] = key[127-32*i -: 32];
    end
    for (int i = 4; i < 44; i++)
    begin
      t = w[i-1];
      if (i % 4 == 0)
      begin
        t = {sub_byte(t[23:16]), sub_byte(t[15:8]), sub_byte(t[7:0]), sub_byte(t[31:24])} ^
            {rcon, 24'h000000};
        rcon = gf_mul(rcon, 8'h02);
      end
      w[i] = w[i-4] ^ t;
    end
    for (int i = 0; i < 16; i++)
    begin
      s[i] = pt[127-8*i -: 8] ^ w[i/4][31-8*(i%4) -: 8];
    end
    for (int r = 1; r <= 10; r++)
    begin
      for (int i = 0; i < 16; i++)
      begin
        s[i] = sub_byte(s[i]);
      end
      // row rr of column c comes from column c+rr
      for (int c = 0; c < 4; c++)
      begin
        for (int rr = 0; rr < 4; rr++)
        begin
          sr[4*c+rr] = s[4*((c+rr)%4)+rr];
        end
      end
      for (int c = 0; c < 4; c++)
      begin
        if (r < 10)
        begin
          s[4*c]   = gf_mul(sr[4*c], 8'h02) ^ gf_mul(sr[4*c+1], 8'h03) ^ sr[4*c+2] ^ sr[4*c+3];
          s[4*c+1] = sr[4*c] ^ gf_mul(sr[4*c+1], 8'h02) ^ gf_mul(sr[4*c+2], 8'h03) ^ sr[4*c+3];
          s[4*c+2] = sr[4*c] ^ sr[4*c+1] ^ gf_mul(sr[4*c+2], 8'h02) ^ gf_mul(sr[4*c+3], 8'h03);
          s[4*c+3] = gf_mul(sr[4*c], 8'h03) ^ sr[4*c+1] ^ sr[4*c+2] ^ gf_mul(sr[4*c+3], 8'h02);
        end
        else
        begin
          // last round, no column mix
          for (int rr = 0; rr < 4; rr++)
          begin
            s[4*c+rr] = sr[4*c+rr];
          end
        end
      end
      for (int i = 0; i < 16; i++)
      begin
        s[i] = s[i] ^ w[4*r + i/4][31-8*(i%4) -: 8];
      end
    end
    for (int i = 0; i < 16; i++)
    begin
      res[127-8*i -: 8] = s[i];
    end
    return res;
  endfunction

  // round number asked for in cycle cyc of a block, cycle 0 is the init cycle
  function automatic round_t expected_round(int cyc);
    if (cyc == 0)
    begin
      return '0;
    end
    return round_t'((cyc - 1) / (`AES_WORDS + 1) + 1);
  endfunction

  // ----------------------------------------
  // watch the core
  // ----------------------------------------
  // all samples are pre-edge values of flops or bench inputs
  always @(posedge clk)
  begin
    if (!self_checked)
    begin
      // model against the published vector first
      expected = encrypt(fips_key, fips_pt);
      if (expected !== fips_ct)
      begin
        $display("MISMATCH at %0t: model output expected %h, got %h", $time, fips_ct, expected);
        err_cnt++;
      end
      $display("model fips-197 vector: %s", (expected === fips_ct) ? "pass" : "fail");
      test_cnt++;
      self_checked = 1'b1;
    end
    if (!reset_n)
    begin
      if (busy)
      begin
        $display("op %0d: stopped by reset", ops);
      end
      busy     = 1'b0;
      in_reset = 1'b1;
    end
    else
    begin
      // first edge out of reset sees the reset values
      if (in_reset)
      begin
        op_ok = 1'b1;
        if (ready !== 1'b1)
        begin
          $display("MISMATCH at %0t: ready expected 1, got %b", $time, ready);
          err_cnt++;
          op_ok = 1'b0;
        end
        if (round !== '0)
        begin
          $display("MISMATCH at %0t: round expected 0, got %0d", $time, round);
          err_cnt++;
          op_ok = 1'b0;
        end
        if (new_block !== '0)
        begin
          $display("MISMATCH at %0t: new_block expected %h, got %h", $time, block_t'(0), new_block);
          err_cnt++;
          op_ok = 1'b0;
        end
        $display("reset values: %s", op_ok ? "pass" : "fail");
        test_cnt++;
        last_result = '0;
        in_reset    = 1'b0;
      end
      if (busy)
      begin
        if (!ready)
        begin
          low_cycles++;
          // key request follows the round schedule, first slip only
          if (round_ok && round !== expected_round(low_cycles - 1))
          begin
            $display("MISMATCH at %0t: round expected %0d, got %0d",
                     $time, expected_round(low_cycles - 1), round);
            err_cnt++;
            round_ok = 1'b0;
          end
        end
        else
        begin
          op_ok = round_ok;
          if (new_block !== expected)
          begin
            $display("MISMATCH at %0t: new_block expected %h, got %h", $time, expected, new_block);
            err_cnt++;
            op_ok = 1'b0;
          end
          if (low_cycles != exp_latency)
          begin
            $display("MISMATCH at %0t: ready latency expected %0d, got %0d",
                     $time, exp_latency, low_cycles);
            err_cnt++;
            op_ok = 1'b0;
          end
          $display("op %0d: %0d cycles, %s", ops, low_cycles, op_ok ? "pass" : "fail");
          test_cnt++;
          last_result = new_block;
          busy        = 1'b0;
        end
      end
      else
      begin
        // idle, ready and result must hold
        if (!ready)
        begin
          $display("MISMATCH at %0t: ready expected 1, got %b", $time, ready);
          err_cnt++;
        end
        if (new_block !== last_result)
        begin
          $display("MISMATCH at %0t: new_block expected %h, got %h", $time, last_result, new_block);
          err_cnt++;
        end
      end
      // start taken only with ready high
      if (next && ready)
      begin
        expected   = encrypt(cipher_key, block);
        low_cycles = 0;
        round_ok   = 1'b1;
        busy       = 1'b1;
        ops++;
      end
    end
  end

endmodule

/* bench/tb_aes.sv */
//----------------------------------------
// aes-128 encipher testbench
// clock, reset, round-key source and the
// known-answer, random and reset tests
//----------------------------------------
`timescale 1ns/1ps

module tb_aes;
  import aes_pkg::*;

  localparam int     ready_limit = 200;
  localparam int     rand_tests  = 40;
  localparam block_t fips_key    = 128'h000102030405060708090a0b0c0d0e0f;
  localparam block_t fips_pt     = 128'h00112233445566778899aabbccddeeff;

  logic   clk;
  logic   reset_n;
  logic   next;
  block_t block;
  block_t round_key;
  round_t round;
  block_t new_block;
  logic   ready;

  block_t cipher_key;
  block_t rk [11];
  int     errors;
  int     tests;
  bit     timed_out;

  aes_encipher_core dut (
    .clk       (clk),
    .reset_n   (reset_n),
    .next      (next),
    .block     (block),
    .round_key (round_key),
    .round     (round),
    .new_block (new_block),
    .ready     (ready)
  );

  aes_checker check (
    .clk        (clk),
    .reset_n    (reset_n),
    .next       (next),
    .ready      (ready),
    .round      (round),
    .cipher_key (cipher_key),
    .block      (block),
    .new_block  (new_block),
    .errors     (errors),
    .tests      (tests)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // key source answers in the same cycle
  assign round_key = (round <= 4'd10) ? rk[round] : '0;

  // ----------------------------------------
  // key expansion for the key source
  // ----------------------------------------
  function automatic logic [7:0] gf_mul(logic [7:0] a, logic [7:0] b);
    logic [7:0] p;
    p = 8'h00;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
      begin
        p = p ^ a;
      end
      a = {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    end
    return p;
  endfunction

  // field inverse, then affine map
  function automatic logic [7:0] sub_byte(logic [7:0] b);
    logic [7:0] sq;
    logic [7:0] inv;
    sq  = b;
    inv = 8'h01;
    for (int i = 1; i < 8; i++)
    begin
      sq  = gf_mul(sq, sq);
      inv = gf_mul(inv, sq);
    end
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^
           {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
  endfunction

  task automatic expand_key(input block_t key);
    logic [31:0] w [44];
    logic [31:0] t;
    logic [7:0]  rcon;
    rcon = 8'h01;
    for (int i = 0; i < 4; i++)
    begin
      w[i] = key[127-32*i -: 32];
    end
    for (int i = 4; i < 44; i++)
    begin
      t = w[i-1];
      if (i % 4 == 0)
      begin
        // rotword, subword, rcon
        t = {sub_byte(t[23:16]), sub_byte(t[15:8]), sub_byte(t[7:0]), sub_byte(t[31:24])} ^
            {rcon, 24'h000000};
        rcon = gf_mul(rcon, 8'h02);
      end
      w[i] = w[i-4] ^ t;
    end
    for (int r = 0; r < 11; r++)
    begin
      rk[r] = {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
    end
  endtask

  // ----------------------------------------
  // stimulus, all on the falling edge
  // ----------------------------------------
  function automatic block_t rand_block();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  task automatic reset_core();
    reset_n = 1'b0;
    repeat (2) @(negedge clk);
    reset_n = 1'b1;
  endtask

  // one-cycle next pulse with key and block set up
  task automatic start_block(input block_t key, input block_t blk);
    @(negedge clk);
    cipher_key = key;
    expand_key(key);
    block = blk;
    next  = 1'b1;
    @(negedge clk);
    next = 1'b0;
  endtask

  // stray_at > 0 pulses next again that many cycles in
  task automatic wait_ready(input int stray_at);
    int n;
    n = 0;
    while (!ready && n < ready_limit)
    begin
      @(negedge clk);
      n++;
      next = (!ready && n == stray_at);
    end
    next = 1'b0;
    if (!ready)
    begin
      $display("timeout: ready still low after %0d cycles at %0t", ready_limit, $time);
      timed_out = 1'b1;
    end
  endtask

  task automatic run_block(input block_t key, input block_t blk, input int stray_at);
    start_block(key, blk);
    wait_ready(stray_at);
  endtask

  task automatic run_tests();
    // known answer, then with a stray start mid-block
    run_block(fips_key, fips_pt, 0);
    if (timed_out)
    begin
      return;
    end
    run_block(fips_key, fips_pt, 17);
    if (timed_out)
    begin
      return;
    end
    // random pairs, every fifth with a stray next
    for (int i = 0; i < rand_tests; i++)
    begin
      run_block(rand_block(), rand_block(), (i % 5 == 2) ? 3 + i : 0);
      if (timed_out)
      begin
        return;
      end
    end
    // reset in the middle of a block, then a clean block
    start_block(rand_block(), rand_block());
    repeat (23) @(negedge clk);
    reset_core();
    run_block(fips_key, fips_pt, 0);
  endtask

  initial
  begin
    clk        = 1'b0;
    reset_n    = 1'b0;
    next       = 1'b0;
    block      = '0;
    cipher_key = '0;
    timed_out  = 1'b0;
    expand_key('0);
    void'($urandom(79));
    reset_core();
    run_tests();
    // let the checker see the last result
    repeat (2) @(negedge clk);
    $display("tests %0d, errors %0d, timeouts %0d", tests, errors, timed_out);
    if (errors == 0 && !timed_out)
    begin
      $display("Everything OK");
    end
    else
    begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* sim.f */
+incdir+src
src/aes_pkg.sv
src/aes_sbox.sv
src/aes_round_logic.sv
src/aes_block_state.sv
src/aes_encipher_ctrl.sv
src/aes_encipher_core.sv
bench/aes_checker.sv
bench/tb_aes.sv

/* Makefile */
# verilator build and run of the aes-128 encipher testbench

SIM  := obj_dir/Vtb_aes
SRCS := $(wildcard src/*.sv src/*.svh bench/*.sv)

all: run

# rebuilt only when a source or the file list changes
$(SIM): sim.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_aes -Mdir obj_dir -f sim.f

run: $(SIM)
	$(SIM) | tee sim.log
	@if grep -q "Something failed" sim.log; then exit 1; fi
	@grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
